// File: design/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // datapath width, address and data alike
    localparam int xlen       = 64;
    localparam int word_bytes = xlen / 8;   // byte step between words
    localparam int id_w       = 4;          // axi id width

    // fixed AR fields for single-beat fetch reads
    localparam logic [2:0] axi_size_full  = 3'd3;    // 8 bytes per beat
    localparam logic [1:0] axi_burst_incr = 2'b01;
    localparam logic [7:0] axi_len_single = 8'd0;    // one beat only

    // unprivileged | secure | data access, all encode as zero
    localparam logic [2:0] axi_prot_default  = 3'b000;
    localparam logic [3:0] axi_cache_default = 4'b0010;  // normal, non-cacheable, non-bufferable
    localparam logic [id_w-1:0] axi_id_fetch = '0;       // single fixed id

    localparam logic [1:0] axi_resp_okay   = 2'b00;
    localparam logic [1:0] axi_resp_slverr = 2'b10;

    // read address channel, 89 bits
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] addr;
        logic [7:0]      len;
        logic [2:0]      size;
        logic [1:0]      burst;
        logic [2:0]      prot;
        logic [3:0]      cache;
        logic [id_w-1:0] id;
    } axi_ar_t;

    // read data channel
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] data;
        logic [1:0]      resp;
        logic            last;
    } axi_r_t;

    // master to fetch stage result
    typedef struct packed {
        logic            done;   // one cycle per served request
        logic [xlen-1:0] addr;   // latched request address
        logic [xlen-1:0] data;
        logic            err;    // bus error on this word
    } fetch_rsp_t;

    // gray order from idle through trans_ok
    typedef enum logic [1:0] {
        idle     = 2'b00,
        ar_wait  = 2'b01,
        r_wait   = 2'b11,
        trans_ok = 2'b10
    } r_state_e;

endpackage

`default_nettype wire

// File: design/fetch_pc.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_pc #(
    parameter logic [fetch_pkg::xlen-1:0] reset_pc = '0
) (
    input  wire                             clock_i,
    input  wire                             reset_i,
    input  wire                             redirect_i,      // one-cycle pulse
    input  wire  [fetch_pkg::xlen-1:0]      redirect_pc_i,
    input  wire  fetch_pkg::fetch_rsp_t     rsp_i,
    output logic                            rw_valid_o,
    output logic [fetch_pkg::xlen-1:0]      rw_addr_o,
    output logic                            instr_valid_o,
    output logic [fetch_pkg::xlen-1:0]      instr_o,
    output logic [fetch_pkg::xlen-1:0]      instr_pc_o,
    output logic                            instr_err_o
);

    logic [fetch_pkg::xlen-1:0] pc_q;       // current fetch address
    logic                       req_q;      // request level, up once out of reset
    logic                       squash_q;   // next done belongs to a pre-redirect read
    logic                       addr_hit;
    logic                       stale_err;
    logic                       deliver;

    // response is for the address we want now
    assign addr_hit  = rsp_i.done && (rsp_i.addr == pc_q);
    // error word left over from a squashed fetch, wait for the repeat
    assign stale_err = rsp_i.err && squash_q;
    assign deliver   = addr_hit && !stale_err && !redirect_i;

    always_ff @(posedge clock_i or negedge reset_i) begin
        if (!reset_i) begin
            pc_q     <= reset_pc;
            req_q    <= 1'b0;
            squash_q <= 1'b0;
        end else begin
            req_q <= 1'b1;                                     // always fetching
            if (redirect_i) begin
                pc_q <= redirect_pc_i;                         // retarget, drop this cycle
            end else if (deliver) begin
                pc_q <= pc_q + fetch_pkg::word_bytes;          // next sequential word
            end
            // a redirect with no done pending leaves a read in flight
            if (redirect_i && !rsp_i.done) begin
                squash_q <= 1'b1;
            end else if (rsp_i.done) begin
                squash_q <= 1'b0;
            end
        end
    end

    assign rw_valid_o    = req_q;
    assign rw_addr_o     = pc_q;

    // result straight off the master response, qualified here
    assign instr_valid_o = deliver;
    assign instr_o       = rsp_i.data;
    assign instr_pc_o    = rsp_i.addr;
    assign instr_err_o   = rsp_i.err;

endmodule

`default_nettype wire

// File: design/axi_read_master.sv
`timescale 1ns/1ns
`default_nettype none

module axi_read_master (
    input  wire                             clock_i,
    input  wire                             reset_i,

    // fetch side, plain levels
    input  wire                             rw_valid_i,
    input  wire  [fetch_pkg::xlen-1:0]      rw_addr_i,
    output fetch_pkg::fetch_rsp_t           rsp_o,

    // axi read channels
    output fetch_pkg::axi_ar_t              ar_o,
    input  wire                             ar_ready_i,
    input  wire  fetch_pkg::axi_r_t         r_i,
    output logic                            r_ready_o
);

    fetch_pkg::r_state_e        state_q;
    fetch_pkg::r_state_e        state_d;
    logic [fetch_pkg::xlen-1:0] addr_q;     // address held for the AR payload
    logic [fetch_pkg::xlen-1:0] data_q;     // last word, reused on repeat
    logic                       err_q;
    logic                       done_q;
    logic                       ar_valid;
    logic                       r_ready;
    logic                       same_addr;
    logic                       r_fire;

    // same word asked again while we still hold it
    assign same_addr = rw_valid_i && (rw_addr_i == addr_q);
    assign r_fire    = r_ready && r_i.valid;

    always_ff @(posedge clock_i or negedge reset_i) begin
        if (!reset_i) begin
            state_q <= fetch_pkg::idle;
        end else begin
            state_q <= state_d;
        end
    end

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            fetch_pkg::idle: begin
                if (rw_valid_i) state_d = fetch_pkg::ar_wait;
            end
            fetch_pkg::ar_wait: begin
                if (ar_ready_i) state_d = fetch_pkg::r_wait;   // AR handshake
            end
            fetch_pkg::r_wait: begin
                if (r_i.valid) state_d = fetch_pkg::trans_ok;  // R handshake
            end
            fetch_pkg::trans_ok: begin
                if (!rw_valid_i) begin
                    state_d = fetch_pkg::idle;
                end else if (!same_addr) begin
                    state_d = fetch_pkg::ar_wait;              // new address, go to bus
                end
            end
            default: state_d = fetch_pkg::idle;
        endcase
    end

    // channel strobes decoded from state
    always_comb begin
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        case (state_q)
            fetch_pkg::ar_wait: ar_valid = 1'b1;
            fetch_pkg::r_wait:  r_ready  = 1'b1;
            default: begin
                ar_valid = 1'b0;
                r_ready  = 1'b0;
            end
        endcase
    end

    // latch on entry to ar_wait so the AR payload holds until ready
    always_ff @(posedge clock_i) begin
        if ((state_d == fetch_pkg::ar_wait) && (state_q != fetch_pkg::ar_wait)) begin
            addr_q <= rw_addr_i;
        end
        if (r_fire) begin
            data_q <= r_i.data;
            err_q  <= (r_i.resp != fetch_pkg::axi_resp_okay) || !r_i.last;
        end
    end

    // done one cycle after R handshake, or after a repeat hit
    always_ff @(posedge clock_i or negedge reset_i) begin
        if (!reset_i) begin
            done_q <= 1'b0;
        end else begin
            done_q <= r_fire
                   || ((state_q == fetch_pkg::trans_ok) && same_addr && !done_q);
        end
    end

    assign rsp_o.done = done_q;
    assign rsp_o.addr = addr_q;
    assign rsp_o.data = data_q;
    assign rsp_o.err  = err_q;

    // single beat incr read, fixed attributes
    assign ar_o.valid = ar_valid;
    assign ar_o.addr  = addr_q;
    assign ar_o.len   = fetch_pkg::axi_len_single;
    assign ar_o.size  = fetch_pkg::axi_size_full;
    assign ar_o.burst = fetch_pkg::axi_burst_incr;
    assign ar_o.prot  = fetch_pkg::axi_prot_default;
    assign ar_o.cache = fetch_pkg::axi_cache_default;
    assign ar_o.id    = fetch_pkg::axi_id_fetch;

    assign r_ready_o  = r_ready;

endmodule

`default_nettype wire

// File: design/axi_sram_slave.sv
`timescale 1ns/1ns
`default_nettype none

module axi_sram_slave #(
    parameter int  mem_words = 64,
    localparam int idx_w     = $clog2(mem_words)
) (
    input  wire                             clock_i,
    input  wire                             reset_i,

    // load port, one word per cycle
    input  wire                             load_en_i,
    input  wire  [idx_w-1:0]                load_addr_i,    // word index
    input  wire  [fetch_pkg::xlen-1:0]      load_data_i,

    // axi read side
    input  wire  fetch_pkg::axi_ar_t        ar_i,
    output logic                            ar_ready_o,
    output fetch_pkg::axi_r_t               r_o,
    input  wire                             r_ready_i
);

    localparam int off_w  = $clog2(fetch_pkg::word_bytes);  // byte offset bits
    localparam int word_w = fetch_pkg::xlen - off_w;

    typedef enum logic [1:0] {
        sl_addr,    // waiting to accept AR
        sl_wait,    // delay before R valid
        sl_data     // R valid up, waiting for ready
    } sl_state_e;

    sl_state_e                  state_q;
    logic [fetch_pkg::xlen-1:0] mem [mem_words];
    logic [15:0]                lfsr_q;
    logic [1:0]                 cnt_q;       // remaining wait cycles
    logic [fetch_pkg::xlen-1:0] rdata_q;
    logic [1:0]                 rresp_q;
    logic [word_w-1:0]          ar_word;
    logic                       ar_oor;
    logic                       ar_fire;
    logic                       r_fire;

    assign ar_word = ar_i.addr[fetch_pkg::xlen-1:off_w];
    assign ar_oor  = ar_word >= word_w'(mem_words);       // past the array
    assign ar_fire = ar_i.valid && ar_ready_o;
    assign r_fire  = r_o.valid && r_ready_i;

    // ready only once the random wait ran out
    assign ar_ready_o = (state_q == sl_addr) && ar_i.valid && (cnt_q == 2'd0);

    // x^16 + x^14 + x^13 + x^11
    always_ff @(posedge clock_i or negedge reset_i) begin
        if (!reset_i) begin
            lfsr_q <= 16'hace1;
        end else begin
            lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
        end
    end

    always_ff @(posedge clock_i) begin
        if (load_en_i) begin
            mem[load_addr_i] <= load_data_i;
        end
        // word sampled at the AR handshake
        if (ar_fire) begin
            rdata_q <= ar_oor ? '0 : mem[ar_word[idx_w-1:0]];
            rresp_q <= ar_oor ? fetch_pkg::axi_resp_slverr : fetch_pkg::axi_resp_okay;
        end
    end

    always_ff @(posedge clock_i or negedge reset_i) begin
        if (!reset_i) begin
            state_q <= sl_addr;
            cnt_q   <= 2'd0;
        end else begin
            case (state_q)
                sl_addr: begin
                    if (ar_fire) begin
                        if (lfsr_q[1:0] == 2'd0) begin
                            state_q <= sl_data;        // no wait, valid next cycle
                        end else begin
                            state_q <= sl_wait;
                            cnt_q   <= lfsr_q[1:0] - 2'd1;
                        end
                    end else if (ar_i.valid && (cnt_q != 2'd0)) begin
                        cnt_q <= cnt_q - 2'd1;         // count only while asked
                    end
                end
                sl_wait: begin
                    if (cnt_q == 2'd0) begin
                        state_q <= sl_data;
                    end else begin
                        cnt_q <= cnt_q - 2'd1;
                    end
                end
                sl_data: begin
                    if (r_fire) begin
                        state_q <= sl_addr;
                        cnt_q   <= lfsr_q[3:2];        // wait before next ar_ready
                    end
                end
                default: state_q <= sl_addr;
            endcase
        end
    end

    assign r_o.valid = (state_q == sl_data);
    assign r_o.data  = rdata_q;
    assign r_o.resp  = rresp_q;
    assign r_o.last  = 1'b1;                           // single beat

endmodule

`default_nettype wire

// File: design/fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top #(
    parameter logic [fetch_pkg::xlen-1:0] reset_pc  = '0,
    parameter int                         mem_words = 64,
    localparam int                        idx_w     = $clog2(mem_words)
) (
    input  wire                             clock,
    input  wire                             reset,
    input  wire                             load_en_i,
    input  wire  [idx_w-1:0]                load_addr_i,
    input  wire  [fetch_pkg::xlen-1:0]      load_data_i,
    input  wire                             redirect_i,
    input  wire  [fetch_pkg::xlen-1:0]      redirect_pc_i,
    output logic                            instr_valid_o,
    output logic [fetch_pkg::xlen-1:0]      instr_o,
    output logic [fetch_pkg::xlen-1:0]      instr_pc_o,
    output logic                            instr_err_o
);

    logic                       rw_valid;
    logic [fetch_pkg::xlen-1:0] rw_addr;
    fetch_pkg::fetch_rsp_t      rsp;       // master result back to pc stage
    fetch_pkg::axi_ar_t         ar;
    logic                       ar_ready;
    fetch_pkg::axi_r_t          r;
    logic                       r_ready;

    fetch_pc #(
        .reset_pc      (reset_pc)
    ) pc_i (
        .clock_i       (clock),
        .reset_i       (reset),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .rsp_i         (rsp),
        .rw_valid_o    (rw_valid),
        .rw_addr_o     (rw_addr),
        .instr_valid_o (instr_valid_o),
        .instr_o       (instr_o),
        .instr_pc_o    (instr_pc_o),
        .instr_err_o   (instr_err_o)
    );

    axi_read_master master_i (
        .clock_i       (clock),
        .reset_i       (reset),
        .rw_valid_i    (rw_valid),
        .rw_addr_i     (rw_addr),
        .rsp_o         (rsp),
        .ar_o          (ar),
        .ar_ready_i    (ar_ready),
        .r_i           (r),
        .r_ready_o     (r_ready)
    );

    axi_sram_slave #(
        .mem_words     (mem_words)
    ) sram_i (
        .clock_i       (clock),
        .reset_i       (reset),
        .load_en_i     (load_en_i),
        .load_addr_i   (load_addr_i),
        .load_data_i   (load_data_i),
        .ar_i          (ar),
        .ar_ready_o    (ar_ready),
        .r_o           (r),
        .r_ready_i     (r_ready)
    );

endmodule

`default_nettype wire

// File: dv/fetch_chk.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_chk (
    input wire                       clock_i,
    input wire                       reset_i,
    input wire fetch_pkg::r_state_e  state_i,
    input wire fetch_pkg::axi_ar_t   ar_i,
    input wire                       ar_ready_i,
    input wire                       r_ready_i,
    input wire                       done_i
);

    // AR request held until the slave takes it
    ar_stable_a: assert property (@(posedge clock_i) disable iff (!reset_i)
        (ar_i.valid && !ar_ready_i) |=> (ar_i.valid && $stable(ar_i.addr)))
        else $error("AR valid or address changed before ar_ready");

    r_ready_a: assert property (@(posedge clock_i) disable iff (!reset_i)
        r_ready_i |-> (state_i == fetch_pkg::r_wait))   // only while waiting for data
        else $error("R ready raised outside r_wait");

    done_pulse_a: assert property (@(posedge clock_i) disable iff (!reset_i)
        done_i |=> !done_i)
        else $error("done held high for two cycles");

    // quiet bus and result while held in reset
    reset_quiet_a: assert property (@(posedge clock_i)
        !reset_i |-> (!ar_i.valid && !done_i))
        else $error("AR valid or done high during reset");

endmodule

bind axi_read_master fetch_chk chk_i (
    .clock_i    (clock_i),
    .reset_i    (reset_i),
    .state_i    (state_q),
    .ar_i       (ar_o),
    .ar_ready_i (ar_ready_i),
    .r_ready_i  (r_ready_o),
    .done_i     (rsp_o.done)
);

`default_nettype wire

// File: dv/fetch_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_tb;

    localparam logic [63:0] reset_pc       = 64'h0;
    localparam int          mem_words      = 64;
    localparam int          idx_w          = $clog2(mem_words);
    localparam int          clk_period     = 40;
    localparam int          reset_cycles   = 10;
    localparam int          stall_limit    = 200;   // cycles with no delivered word
    localparam int          rt_cycles      = 16;    // worst round trip, both slave waits at 3
    localparam int          seq_fetches    = 40;
    localparam int          redir_count    = 30;
    localparam int          redir_gap      = 24;    // max idle cycles between redirects
    localparam int          repeat_count   = 8;
    localparam int          repeat_pulses  = 9;     // redirect train per repeat round
    localparam int          oor_fetches    = 6;
    localparam int          reload_fetches = 20;
    localparam logic [63:0] park_pc        = 64'h0000_0000_0001_0000;  // far out of range

    // every fetch and every redirect may cost two round trips, plus loads and gaps
    localparam int fetch_total    = seq_fetches + 5 + repeat_count + 4 * oor_fetches
                                  + 1 + reload_fetches;
    localparam int redirect_total = redir_count + repeat_pulses * repeat_count + 4 + 2;
    localparam int watchdog_cycles = reset_cycles + 2 * (mem_words + 1)
                                   + redir_count * (redir_gap + 2)
                                   + (fetch_total + redirect_total) * 2 * rt_cycles + 500;

    logic              clock;
    logic              reset;
    logic              load_en;
    logic [idx_w-1:0]  load_addr;
    logic [63:0]       load_data;
    logic              redirect;
    logic [63:0]       redirect_pc;
    logic              instr_valid;
    logic [63:0]       instr;
    logic [63:0]       instr_pc;
    logic              instr_err;

    logic [63:0] shadow [mem_words];   // memory as the testbench expects it
    logic [63:0] exp_pc;
    int          deliv_cnt    = 0;
    int          err_seen     = 0;     // delivered words flagged as bus error
    int          check_cnt    = 0;
    int          error_cnt    = 0;
    int          stall_cycles = 0;
    int          phase_del0;
    int          phase_err0;

    fetch_top #(
        .reset_pc      (reset_pc),
        .mem_words     (mem_words)
    ) dut_i (
        .clock         (clock),
        .reset         (reset),
        .load_en_i     (load_en),
        .load_addr_i   (load_addr),
        .load_data_i   (load_data),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .instr_valid_o (instr_valid),
        .instr_o       (instr),
        .instr_pc_o    (instr_pc),
        .instr_err_o   (instr_err)
    );

    initial clock = 1'b0;
    always #(clk_period / 2) clock = ~clock;

    initial begin
        reset <= 1'b0;
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b1;
    end

    // fetch model, sampled mid-cycle when all inputs and outputs are settled
    always @(negedge clock) begin : model
        logic [63:0] widx;
        logic        exp_err;
        logic [63:0] exp_data;
        stall_cycles = stall_cycles + 1;
        if (!reset) begin
            exp_pc       = reset_pc;
            stall_cycles = 0;
        end else if (redirect) begin
            exp_pc = redirect_pc;                // retarget, nothing delivered now
            if (instr_valid) begin
                $display("Mismatch at %0t: word delivered in a redirect cycle", $time);
                error_cnt = error_cnt + 1;
            end
        end else if (instr_valid) begin
            widx      = exp_pc >> 3;
            exp_err   = (widx >= mem_words);
            exp_data  = exp_err ? 64'h0 : shadow[widx[idx_w-1:0]];
            check_cnt = check_cnt + 1;
            deliv_cnt = deliv_cnt + 1;
            stall_cycles = 0;
            if (instr_err) err_seen = err_seen + 1;
            if (instr_pc !== exp_pc) begin
                $display("Mismatch at %0t: pc %h, expected %h", $time, instr_pc, exp_pc);
                error_cnt = error_cnt + 1;
            end else if (instr_err !== exp_err) begin
                $display("Mismatch at %0t: err %b at pc %h, expected %b",
                         $time, instr_err, instr_pc, exp_err);
                error_cnt = error_cnt + 1;
            end else if (instr !== exp_data) begin
                $display("Mismatch at %0t: data %h at pc %h, expected %h",
                         $time, instr, instr_pc, exp_data);
                error_cnt = error_cnt + 1;
            end
            exp_pc = exp_pc + 64'd8;             // next sequential word
        end
    end

    task automatic pulse_redirect(input logic [63:0] target);
        @(posedge clock);
        redirect    <= 1'b1;
        redirect_pc <= target;
        @(posedge clock);
        redirect    <= 1'b0;
    endtask

    // whole array, new random words, shadow kept in step
    task automatic load_memory();
        logic [63:0] word;
        for (int i = 0; i < mem_words; i++) begin
            @(posedge clock);
            word         = {$urandom, $urandom};
            load_en     <= 1'b1;
            load_addr   <= idx_w'(i);
            load_data   <= word;
            shadow[i]    = word;
        end
        @(posedge clock);
        load_en <= 1'b0;
    endtask

    task automatic wait_fetches(input int n, input string name);
        int target;
        target = deliv_cnt + n;
        while (deliv_cnt < target) begin
            @(posedge clock);
            if (stall_cycles > stall_limit) begin
                $display("test %s: no instruction delivered for %0d cycles", name, stall_cycles);
                error_cnt = error_cnt + 1;
                return;
            end
        end
    endtask

    task automatic start_test();
        phase_del0 = deliv_cnt;
        phase_err0 = error_cnt;
    endtask

    task automatic end_test(input string name);
        $display("test %-12s %0d words delivered, %0d errors",
                 name, deliv_cnt - phase_del0, error_cnt - phase_err0);
    endtask

    initial begin : main_seq
        int unsigned rnd;
        logic [63:0] target;
        int          err0;
        rnd = $urandom(32'h44ac_4d7a);
        load_en     <= 1'b0;
        load_addr   <= '0;
        load_data   <= '0;
        redirect    <= 1'b0;
        redirect_pc <= '0;

        // loading runs ahead of the fetch stream, which starts after reset
        start_test();
        load_memory();
        wait_fetches(seq_fetches, "sequential");
        end_test("sequential");

        start_test();
        repeat (redir_count) begin
            repeat ($urandom % redir_gap) @(posedge clock);
            pulse_redirect(64'(($urandom % mem_words) * 8));
        end
        wait_fetches(5, "redirect");
        end_test("redirect");

        start_test();
        target = 64'(($urandom % mem_words) * 8);
        for (int i = 0; i < repeat_count; i++) begin
            // pulses every other cycle, a done that meets one is held and served again
            repeat (repeat_pulses) pulse_redirect(target);
            wait_fetches(1, "repeat");
        end
        end_test("repeat");

        start_test();
        repeat (2) begin
            err0 = err_seen;
            pulse_redirect(64'((mem_words + $urandom % mem_words) * 8));
            wait_fetches(oor_fetches, "out_of_range");
            if (err_seen - err0 < oor_fetches) begin
                $display("test out_of_range: fewer error words than expected were delivered");
                error_cnt = error_cnt + 1;
            end
            pulse_redirect(64'(($urandom % (mem_words - oor_fetches - 2)) * 8));
            wait_fetches(oor_fetches, "out_of_range");
        end
        end_test("out_of_range");

        // park out of range so no held or in-flight word sees the old array
        start_test();
        pulse_redirect(park_pc);
        wait_fetches(1, "reload");
        load_memory();
        @(posedge clock);
        pulse_redirect(64'(($urandom % (mem_words - reload_fetches)) * 8));
        wait_fetches(reload_fetches, "reload");
        end_test("reload");

        $display("checks %0d, errors %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog: run did not finish within %0d cycles", watchdog_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
design/fetch_pkg.sv
design/fetch_pc.sv
design/axi_read_master.sv
design/axi_sram_slave.sv
design/fetch_top.sv
dv/fetch_chk.sv
dv/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_subsystem

sources:
  - design/fetch_pkg.sv
  - design/fetch_pc.sv
  - design/axi_read_master.sv
  - design/axi_sram_slave.sv
  - design/fetch_top.sv
  - target: test
    files:
      - dv/fetch_chk.sv
      - dv/fetch_tb.sv
